// ==== Makefile ====
TOOL    = verilator
FLAGS   = --binary --timing --assert -Wno-fatal
TOP     = tb_rv_core
FILES   = list.f
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILES)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "\*\*\* PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/decoder.sv ====
////////////////////////////////////////////////////////////////////////////
// single lane instruction decoder, combinational
// control fields by ISA pattern match and the immediate for opb
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rv_isa.svh"

module decoder (
    input  rv_pkg::inst_packet_t    inst,
    output rv_pkg::fu_type_e        fu_type,
    output rv_pkg::opa_sel_e        opa_select,
    output rv_pkg::opb_sel_e        opb_select,
    output rv_pkg::alu_func_e       alu_func,
    output logic                    has_dest, // writes rd
    output logic                    mult, rd_mem, wr_mem, cond_branch, uncond_branch,
    output logic                    csr_op,
    output logic                    halt,
    output logic                    illegal,
    output logic [rv_pkg::xlen-1:0] imm
);

    logic [31:0] iw;

    // alu function from funct3, alt picks sub and sra
    function automatic rv_pkg::alu_func_e op_func(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  op_func = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  op_func = rv_pkg::alu_sll;
            3'b010:  op_func = rv_pkg::alu_slt;
            3'b011:  op_func = rv_pkg::alu_sltu;
            3'b100:  op_func = rv_pkg::alu_xor;
            3'b101:  op_func = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  op_func = rv_pkg::alu_or;
            default: op_func = rv_pkg::alu_and;
        endcase
    endfunction

    assign iw = inst.inst;

    always_comb begin
        // nop-like defaults
        fu_type       = rv_pkg::fu_alu;
        opa_select    = rv_pkg::opa_is_rs1;
        opb_select    = rv_pkg::opb_is_rs2;
        alu_func      = rv_pkg::alu_add;
        has_dest      = 1'b0;
        mult          = 1'b0;
        rd_mem        = 1'b0;
        wr_mem        = 1'b0;
        cond_branch   = 1'b0;
        uncond_branch = 1'b0;
        csr_op        = 1'b0;
        halt          = 1'b0;
        illegal       = 1'b0;

        if (inst.valid) begin
            casez (iw)
                `RV32_LUI, `RV32_AUIPC: begin
                    has_dest   = 1'b1;
                    opa_select = iw[5] ? rv_pkg::opa_is_zero : rv_pkg::opa_is_pc;
                    opb_select = rv_pkg::opb_is_u_imm;
                end
                `RV32_JAL, `RV32_JALR: begin
                    has_dest      = 1'b1;
                    uncond_branch = 1'b1;
                    fu_type       = rv_pkg::fu_br;
                    opa_select    = iw[3] ? rv_pkg::opa_is_pc : rv_pkg::opa_is_rs1;
                    opb_select    = iw[3] ? rv_pkg::opb_is_j_imm : rv_pkg::opb_is_i_imm;
                end
                `RV32_BRANCH: begin
                    if (iw[14:13] == 2'b01) begin // funct3 010 and 011 are reserved
                        illegal = 1'b1;
                    end else begin
                        opa_select  = rv_pkg::opa_is_pc;
                        opb_select  = rv_pkg::opb_is_b_imm;
                        cond_branch = 1'b1;
                        fu_type     = rv_pkg::fu_br;
                    end
                end
                `RV32_LB, `RV32_LH, `RV32_LW, `RV32_LBU, `RV32_LHU: begin
                    has_dest   = 1'b1;
                    opb_select = rv_pkg::opb_is_i_imm;
                    rd_mem     = 1'b1;
                    fu_type    = rv_pkg::fu_ld;
                end
                `RV32_SB, `RV32_SH, `RV32_SW: begin
                    opb_select = rv_pkg::opb_is_s_imm;
                    wr_mem     = 1'b1;
                    fu_type    = rv_pkg::fu_store;
                end
                `RV32_SLLI, `RV32_SRLI, `RV32_SRAI: begin
                    has_dest   = 1'b1;
                    opb_select = rv_pkg::opb_is_i_imm;
                    alu_func   = op_func(iw[14:12], iw[30]);
                end
                `RV32_OPIMM: begin
                    if (iw[13:12] == 2'b01) begin // shifts with bad funct7 land here
                        illegal = 1'b1;
                    end else begin
                        has_dest   = 1'b1;
                        opb_select = rv_pkg::opb_is_i_imm;
                        alu_func   = op_func(iw[14:12], 1'b0);
                    end
                end
                `RV32_OP, `RV32_SUB, `RV32_SRA: begin
                    has_dest = 1'b1;
                    alu_func = op_func(iw[14:12], iw[30]);
                end
                `RV32_MULDIV: begin
                    has_dest = 1'b1;
                    mult     = 1'b1;
                    fu_type  = rv_pkg::fu_mult;
                end
                `RV32_CSRRW, `RV32_CSRRS, `RV32_CSRRC: begin
                    csr_op  = 1'b1;
                    fu_type = rv_pkg::fu_csr;
                end
                `WFI: begin
                    halt = 1'b1;
                end
                default: begin
                    illegal = 1'b1;
                end
            endcase
        end
    end

    // immediate follows the opb select
    always_comb begin
        case (opb_select)
            rv_pkg::opb_is_i_imm: imm = {{20{iw[31]}}, iw[31:20]};
            rv_pkg::opb_is_s_imm: imm = {{20{iw[31]}}, iw[31:25], iw[11:7]};
            rv_pkg::opb_is_b_imm: imm = {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
            rv_pkg::opb_is_u_imm: imm = {iw[31:12], 12'b0};
            rv_pkg::opb_is_j_imm: imm = {{11{iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};
            default:              imm = '0; // register operand
        endcase
    end

endmodule

// ==== hdl/regfile.sv ====
////////////////////////////////////////////////////////////////////////////
// architectural register file, 2N read and N write ports
// x0 reads zero, higher write lane wins on a shared index
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module regfile #(
    parameter int N = 2
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  rv_pkg::reg_idx_t [2*N-1:0]           rd_idx,
    output logic [2*N-1:0][rv_pkg::xlen-1:0]     rd_data,
    input  rv_pkg::wb_port_t [N-1:0]             wb_ports
);

    logic [rv_pkg::xlen-1:0] regs [rv_pkg::reg_count-1:1]; // no storage for x0

    always_comb begin
        for (int p = 0; p < 2*N; p++) begin
            rd_data[p] = (rd_idx[p] == rv_pkg::zero_reg) ? '0 : regs[rd_idx[p]];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 1; r < rv_pkg::reg_count; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < N; l++) begin // ascending, so the last lane sticks
                if (wb_ports[l].en && wb_ports[l].idx != rv_pkg::zero_reg) begin
                    regs[wb_ports[l].idx] <= wb_ports[l].data;
                end
            end
        end
    end

endmodule

// ==== hdl/rv_core_top.sv ====
////////////////////////////////////////////////////////////////////////////
// top level of the N-wide datapath
// decode, execute and result stages around the register file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_core_top #(
    parameter int N = 2
) (
    input  logic                            clock,
    input  logic                            reset,
    input  rv_pkg::inst_packet_t [N-1:0]    insts,
    output rv_pkg::retire_packet_t [N-1:0]  retire,
    output logic                            halted
);

    rv_pkg::reg_idx_t [2*N-1:0]          rd_idx;
    logic [2*N-1:0][rv_pkg::xlen-1:0]    rd_data;
    rv_pkg::decoded_packet_t [N-1:0]     id_packet;
    rv_pkg::retire_packet_t [N-1:0]      ex_packet;
    rv_pkg::wb_port_t [N-1:0]            wb_ports;

    stage_id #(.N(N)) stage_id_i (
        .clock     (clock),
        .reset     (reset),
        .insts     (insts),
        .rd_idx    (rd_idx),
        .rd_data   (rd_data),
        .id_packet (id_packet)
    );

    regfile #(.N(N)) regfile_i (
        .clock    (clock),
        .reset    (reset),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data),
        .wb_ports (wb_ports)
    );

    stage_ex #(.N(N)) stage_ex_i (
        .clock     (clock),
        .reset     (reset),
        .id_packet (id_packet),
        .ex_packet (ex_packet)
    );

    stage_wb #(.N(N)) stage_wb_i (
        .clock     (clock),
        .reset     (reset),
        .ex_packet (ex_packet),
        .wb_ports  (wb_ports),
        .retire    (retire),
        .halted    (halted)
    );

endmodule

// ==== hdl/rv_isa.svh ====
////////////////////////////////////////////////////////////////////////////
// casez match patterns for RV32I, RV32M, the base CSR ops and WFI
// fields are funct7_rs2_rs1_funct3_rd_opcode
////////////////////////////////////////////////////////////////////////////

`ifndef RV_ISA_SVH
`define RV_ISA_SVH

`define RV32_LUI    32'b???????_?????_?????_???_?????_0110111
`define RV32_AUIPC  32'b???????_?????_?????_???_?????_0010111
`define RV32_JAL    32'b???????_?????_?????_???_?????_1101111
`define RV32_JALR   32'b???????_?????_?????_000_?????_1100111
`define RV32_BRANCH 32'b???????_?????_?????_???_?????_1100011 // funct3 checked apart
`define RV32_LB     32'b???????_?????_?????_000_?????_0000011
`define RV32_LH     32'b???????_?????_?????_001_?????_0000011
`define RV32_LW     32'b???????_?????_?????_010_?????_0000011
`define RV32_LBU    32'b???????_?????_?????_100_?????_0000011
`define RV32_LHU    32'b???????_?????_?????_101_?????_0000011
`define RV32_SB     32'b???????_?????_?????_000_?????_0100011
`define RV32_SH     32'b???????_?????_?????_001_?????_0100011
`define RV32_SW     32'b???????_?????_?????_010_?????_0100011
`define RV32_OPIMM  32'b???????_?????_?????_???_?????_0010011 // addi slti sltiu xori ori andi
`define RV32_SLLI   32'b0000000_?????_?????_001_?????_0010011
`define RV32_SRLI   32'b0000000_?????_?????_101_?????_0010011
`define RV32_SRAI   32'b0100000_?????_?????_101_?????_0010011
`define RV32_OP     32'b0000000_?????_?????_???_?????_0110011 // add sll slt sltu xor srl or and
`define RV32_SUB    32'b0100000_?????_?????_000_?????_0110011
`define RV32_SRA    32'b0100000_?????_?????_101_?????_0110011
`define RV32_MULDIV 32'b0000001_?????_?????_???_?????_0110011 // mul mulh* div* rem*
`define RV32_CSRRW  32'b???????_?????_?????_001_?????_1110011
`define RV32_CSRRS  32'b???????_?????_?????_010_?????_1110011
`define RV32_CSRRC  32'b???????_?????_?????_011_?????_1110011
`define WFI         32'b0001000_00101_00000_000_00000_1110011

`endif

// ==== hdl/rv_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// shared types of the N-wide RV32I datapath
// widths, enums for unit type, ALU function and operand selects,
// and the packets passed between the stages and the register file
////////////////////////////////////////////////////////////////////////////

package rv_pkg;

    localparam int xlen      = 32;
    localparam int reg_count = 32;

    typedef logic [$clog2(reg_count)-1:0] reg_idx_t;

    localparam reg_idx_t zero_reg = '0; // destination when none exists

    typedef enum logic [2:0] {
        fu_alu, fu_br, fu_mult, fu_ld, fu_store, fu_csr
    } fu_type_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and,
        alu_or, alu_xor, alu_sll, alu_srl, alu_sra
    } alu_func_e;

    typedef enum logic [1:0] {
        opa_is_rs1, opa_is_pc, opa_is_zero
    } opa_sel_e;

    typedef enum logic [2:0] {
        opb_is_rs2, opb_is_i_imm, opb_is_s_imm, opb_is_b_imm, opb_is_u_imm, opb_is_j_imm
    } opb_sel_e;

    // fetched instruction, one per lane
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] npc;
        logic [31:0]     inst;
    } inst_packet_t;

    // decode to execute
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] npc;
        logic [31:0]     inst;
        logic [xlen-1:0] rs1_value;
        logic [xlen-1:0] rs2_value;
        logic [xlen-1:0] imm;
        reg_idx_t        dest_reg_idx;
        fu_type_e        fu_type;
        opa_sel_e        opa_select;
        opb_sel_e        opb_select;
        alu_func_e       alu_func;
        logic            cond_branch;
        logic            uncond_branch;
        logic            rd_mem;
        logic            wr_mem;
        logic            mult;
        logic            csr_op;
        logic            halt;
        logic            illegal;
    } decoded_packet_t;

    // execute to result, and the retire view seen outside
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        reg_idx_t        dest_reg_idx;
        logic [xlen-1:0] result;
        logic            take_branch;
        logic [xlen-1:0] target;
        fu_type_e        fu_type;
        logic            halt;
        logic            illegal;
    } retire_packet_t;

    typedef struct packed {
        logic            en;
        reg_idx_t        idx;
        logic [xlen-1:0] data;
    } wb_port_t;

endpackage

// ==== hdl/stage_ex.sv ====
////////////////////////////////////////////////////////////////////////////
// execute stage: per lane ALU, branch compare and target,
// and the execute-to-result register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stage_ex #(
    parameter int N = 2
) (
    input  logic                             clock,
    input  logic                             reset,
    input  rv_pkg::decoded_packet_t [N-1:0]  id_packet,
    output rv_pkg::retire_packet_t [N-1:0]   ex_packet
);

    rv_pkg::retire_packet_t [N-1:0] ex_next;

    for (genvar i = 0; i < N; i++) begin : g_lane
        rv_pkg::decoded_packet_t d;
        logic [rv_pkg::xlen-1:0] opa, opb, alu_out, base;
        logic                    cond, is_jalr;

        assign d       = id_packet[i];
        assign is_jalr = d.uncond_branch && d.opa_select == rv_pkg::opa_is_rs1;

        ////////////////////////////////////////////////////////////////////////////
        // operands and ALU
        ////////////////////////////////////////////////////////////////////////////
        always_comb begin
            case (d.opa_select)
                rv_pkg::opa_is_pc: opa = d.pc;
                rv_pkg::opa_is_zero: opa = '0;
                default: opa = d.rs1_value;
            endcase
            opb = (d.opb_select == rv_pkg::opb_is_rs2) ? d.rs2_value : d.imm;

            case (d.alu_func)
                rv_pkg::alu_sub:  alu_out = opa - opb;
                rv_pkg::alu_slt:  alu_out = {31'b0, $signed(opa) < $signed(opb)};
                rv_pkg::alu_sltu: alu_out = {31'b0, opa < opb};
                rv_pkg::alu_and:  alu_out = opa & opb;
                rv_pkg::alu_or:   alu_out = opa | opb;
                rv_pkg::alu_xor:  alu_out = opa ^ opb;
                rv_pkg::alu_sll:  alu_out = opa << opb[4:0];
                rv_pkg::alu_srl:  alu_out = opa >> opb[4:0];
                rv_pkg::alu_sra:  alu_out = $signed(opa) >>> opb[4:0];
                default:          alu_out = opa + opb;
            endcase
        end

        // branch condition by funct3
        always_comb begin
            case (d.inst[14:12])
                3'b000:  cond = d.rs1_value == d.rs2_value;
                3'b001:  cond = d.rs1_value != d.rs2_value;
                3'b100:  cond = $signed(d.rs1_value) < $signed(d.rs2_value);
                3'b101:  cond = $signed(d.rs1_value) >= $signed(d.rs2_value);
                3'b110:  cond = d.rs1_value < d.rs2_value;
                default: cond = d.rs1_value >= d.rs2_value;
            endcase
        end

        assign base = is_jalr ? d.rs1_value : d.pc;

        assign ex_next[i].valid        = d.valid;
        assign ex_next[i].pc           = d.pc;
        assign ex_next[i].dest_reg_idx = d.dest_reg_idx;
        assign ex_next[i].result       = d.uncond_branch ? d.npc : alu_out; // link value
        assign ex_next[i].take_branch  = d.uncond_branch || (d.cond_branch && cond);
        assign ex_next[i].target       = (base + d.imm) & ~{{(rv_pkg::xlen-1){1'b0}}, is_jalr};
        assign ex_next[i].fu_type      = d.fu_type;
        assign ex_next[i].halt         = d.halt;
        assign ex_next[i].illegal      = d.illegal;
    end

    always_ff @(posedge clock) begin
        ex_packet <= ex_next;
        if (reset) begin
            for (int i = 0; i < N; i++) begin
                ex_packet[i].valid <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/stage_id.sv ====
////////////////////////////////////////////////////////////////////////////
// decode stage: N decoders, operand reads, destination masking
// and the decode-to-execute register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stage_id #(
    parameter int N = 2
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  rv_pkg::inst_packet_t [N-1:0]         insts,
    output rv_pkg::reg_idx_t [2*N-1:0]           rd_idx,
    input  logic [2*N-1:0][rv_pkg::xlen-1:0]     rd_data,
    output rv_pkg::decoded_packet_t [N-1:0]      id_packet
);

    rv_pkg::decoded_packet_t [N-1:0] id_next;
    logic [N-1:0]                    has_dest;

    for (genvar i = 0; i < N; i++) begin : g_lane
        decoder decoder_i (
            .inst          (insts[i]),
            .fu_type       (id_next[i].fu_type),
            .opa_select    (id_next[i].opa_select),
            .opb_select    (id_next[i].opb_select),
            .alu_func      (id_next[i].alu_func),
            .has_dest      (has_dest[i]),
            .mult          (id_next[i].mult),
            .rd_mem        (id_next[i].rd_mem),
            .wr_mem        (id_next[i].wr_mem),
            .cond_branch   (id_next[i].cond_branch),
            .uncond_branch (id_next[i].uncond_branch),
            .csr_op        (id_next[i].csr_op),
            .halt          (id_next[i].halt),
            .illegal       (id_next[i].illegal),
            .imm           (id_next[i].imm)
        );

        assign rd_idx[2*i]   = insts[i].inst[19:15]; // rs1
        assign rd_idx[2*i+1] = insts[i].inst[24:20]; // rs2

        assign id_next[i].valid        = insts[i].valid;
        assign id_next[i].pc           = insts[i].pc;
        assign id_next[i].npc          = insts[i].npc;
        assign id_next[i].inst         = insts[i].inst;
        assign id_next[i].rs1_value    = rd_data[2*i];
        assign id_next[i].rs2_value    = rd_data[2*i+1];
        assign id_next[i].dest_reg_idx = has_dest[i] ? insts[i].inst[11:7] : rv_pkg::zero_reg;
    end

    always_ff @(posedge clock) begin
        id_packet <= id_next;
        if (reset) begin
            for (int i = 0; i < N; i++) begin
                id_packet[i].valid <= 1'b0;
            end
        end
    end

endmodule

// ==== hdl/stage_wb.sv ====
////////////////////////////////////////////////////////////////////////////
// result stage: register write ports, retire packets, halt tracking
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stage_wb #(
    parameter int N = 2
) (
    input  logic                            clock,
    input  logic                            reset,
    input  rv_pkg::retire_packet_t [N-1:0]  ex_packet,
    output rv_pkg::wb_port_t [N-1:0]        wb_ports,
    output rv_pkg::retire_packet_t [N-1:0]  retire,
    output logic                            halted
);

    logic [N:0] kill; // kill[i] blanks lane i and above
    logic [N-1:0] live;

    assign kill[0] = halted;

    for (genvar i = 0; i < N; i++) begin : g_lane
        logic writes_reg;

        assign live[i]       = ex_packet[i].valid && !kill[i];
        assign kill[i+1]     = kill[i] || (live[i] && ex_packet[i].halt);
        assign writes_reg    = ex_packet[i].fu_type == rv_pkg::fu_alu ||
                               ex_packet[i].fu_type == rv_pkg::fu_br;

        always_comb begin
            retire[i]       = ex_packet[i];
            retire[i].valid = live[i];
        end

        assign wb_ports[i].en   = live[i] && writes_reg && !ex_packet[i].illegal &&
                                  ex_packet[i].dest_reg_idx != rv_pkg::zero_reg;
        assign wb_ports[i].idx  = ex_packet[i].dest_reg_idx;
        assign wb_ports[i].data = ex_packet[i].result;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            halted <= 1'b0;
        end else begin
            halted <= kill[N]; // sticky until reset
        end
    end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/stage_id.sv
hdl/stage_ex.sv
hdl/stage_wb.sv
hdl/rv_core_top.sv
tb/rv_core_sva.sv
tb/tb_rv_core.sv

// ==== tb/rv_core_sva.sv ====
////////////////////////////////////////////////////////////////////////////
// concurrent assertions on the result stage
// write index, sticky halt and no retire while halted
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_core_sva #(
    parameter int N = 2
) (
    input logic                            clock,
    input logic                            reset,
    input rv_pkg::wb_port_t [N-1:0]        wb_ports,
    input rv_pkg::retire_packet_t [N-1:0]  retire,
    input logic                            halted
);

    int fail_count = 0; // failed assertions so far

    for (genvar i = 0; i < N; i++) begin : g_lane
        wb_idx_nonzero: assert property (@(posedge clock) disable iff (reset)
            wb_ports[i].en |-> wb_ports[i].idx != rv_pkg::zero_reg)
            else begin
                fail_count++;
                $error("write enable with index zero on lane %0d", i);
            end

        no_retire_halted: assert property (@(posedge clock) disable iff (reset)
            halted |-> !retire[i].valid)
            else begin
                fail_count++;
                $error("retire valid on lane %0d while halted", i);
            end
    end

    halted_sticky: assert property (@(posedge clock) disable iff (reset)
        halted |=> halted)
        else begin
            fail_count++;
            $error("halted dropped without reset");
        end

endmodule

// ==== tb/rv_core_vectors.hex ====
// halted, then per lane: ctl pc inst dest result target
// ctl digits: in valid, retire valid, take_branch, halt, illegal, fu_type
// result checked for alu/br with nonzero dest, target for br only
0 110000 100 00500093 01 00000005 0 110000 104 ffd00113 02 fffffffd 0
0 110000 108 123451b7 03 12345000 0 110000 10c 7ff00213 04 000007ff 0
0 110000 110 00100293 05 00000001 0 110000 114 fff04313 06 ffffffff 0
0 110000 118 002083b3 07 00000002 0 110000 11c 40208433 08 00000008 0
0 110000 120 001124b3 09 00000001 0 110000 124 00113533 0a 00000000 0
0 110000 128 005215b3 0b 00000ffe 0 110000 12c 40515633 0c fffffffe 0
0 110000 130 005156b3 0d 7ffffffe 0 110000 134 0041c733 0e 123457ff 0
0 110000 138 0011e7b3 0f 12345005 0 110000 13c 00437833 10 000007ff 0
0 110000 140 ffe12893 11 00000001 0 110000 144 0030b913 12 00000000 0
0 110000 148 0f00e993 13 000000f5 0 110000 14c 55537a13 14 00000555 0
0 110000 150 00409a93 15 00000050 0 110000 154 01c15b13 16 0000000f 0
0 110000 158 40115b93 17 fffffffe 0 110000 15c 00001c17 18 0000115c 0
0 111001 160 01000cef 19 00000164 00000170 111001 164 00208d67 1a 00000168 00000006
0 111001 168 00108463 00 0 00000170 110001 16c 00109463 00 0 00000174
0 111001 170 fe114ee3 00 0 0000016c 110001 174 00115663 00 0 00000180
0 110001 178 00116863 00 0 00000188 111001 17c fe117ce3 00 0 00000174
0 110003 180 0080a283 05 0 0 110004 184 0020a223 00 0 0
0 110002 188 02208333 06 0 0 110005 18c 300093f3 00 0 0
0 110010 190 ffffffff 00 0 0 110000 194 00708013 00 0 0
0 110000 198 11100d93 1b 00000111 0 110000 19c 22200d93 1b 00000222 0
0 110000 1a0 00628e33 1c 00000000 0 110000 1a4 00706eb3 1d 00000002 0
0 000000 1a8 00000013 00 0 0 110000 1ac 00900f13 1e 00000009 0
0 110000 1b0 008d8fb3 1f 0000022a 0 000000 1b4 00000013 00 0 0
0 110100 1b8 10500073 00 0 0 100000 1bc 00100093 00 0 0
1 100000 1c0 00700113 00 0 0 100000 1c4 00700193 00 0 0
1 100000 1c8 002083b3 00 0 0 000000 1cc 00000013 00 0 0
ffffffff

// ==== tb/tb_rv_core.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for the N-wide RV32I datapath
// reads bundles and expected retire fields from the vector file,
// drives one bundle per cycle and checks retire two cycles later
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_rv_core;

    localparam int N          = 2;
    localparam int lane_words = 6;              // ctl pc inst dest result target
    localparam int line_words = 1 + N*lane_words;
    localparam int max_lines  = 64;

    logic                           clock;
    logic                           reset;
    rv_pkg::inst_packet_t [N-1:0]   insts;
    rv_pkg::retire_packet_t [N-1:0] retire;
    logic                           halted;

    logic [31:0] vec_mem [0:line_words*max_lines-1];
    int          vec_count;

    rv_core_top #(.N(N)) dut_i (
        .clock  (clock),
        .reset  (reset),
        .insts  (insts),
        .retire (retire),
        .halted (halted)
    );

    bind stage_wb rv_core_sva #(.N(N)) sva_i (
        .clock    (clock),
        .reset    (reset),
        .wb_ports (wb_ports),
        .retire   (retire),
        .halted   (halted)
    );

    always #20 clock = ~clock;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic drive_bundle(input int b);
        int w;
        for (int l = 0; l < N; l++) begin
            w = b*line_words + 1 + l*lane_words;
            insts[l].valid = vec_mem[w][20];
            insts[l].pc    = vec_mem[w+1];
            insts[l].npc   = vec_mem[w+1] + 32'd4; // sequential fetch
            insts[l].inst  = vec_mem[w+2];
        end
    endtask

    task automatic idle_bundle();
        insts = '0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // retire checks for one bundle
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_bundle(input int b);
        int          w;
        logic [31:0] ctl;
        logic [31:0] dest;
        logic [2:0]  fu;
        logic        exp_valid;
        logic        is_alu_br;
        logic        exp_wb;
        string       tag;
        check_value($sformatf("bundle %0d halted", b), vec_mem[b*line_words], 32'(halted));
        for (int l = 0; l < N; l++) begin
            w         = b*line_words + 1 + l*lane_words;
            ctl       = vec_mem[w];
            dest      = vec_mem[w+3];
            fu        = ctl[2:0];
            exp_valid = ctl[16];
            is_alu_br = fu == rv_pkg::fu_alu || fu == rv_pkg::fu_br;
            exp_wb    = exp_valid && is_alu_br && !ctl[4] && dest != 32'd0;
            tag       = $sformatf("bundle %0d lane %0d", b, l);
            check_value({tag, " valid"}, 32'(exp_valid), 32'(retire[l].valid));
            check_value({tag, " write enable"}, 32'(exp_wb), 32'(dut_i.wb_ports[l].en));
            if (exp_valid) begin
                check_value({tag, " pc"}, vec_mem[w+1], retire[l].pc);
                check_value({tag, " take_branch"}, 32'(ctl[12]), 32'(retire[l].take_branch));
                check_value({tag, " halt"}, 32'(ctl[8]), 32'(retire[l].halt));
                check_value({tag, " illegal"}, 32'(ctl[4]), 32'(retire[l].illegal));
                check_value({tag, " fu_type"}, 32'(fu), 32'(retire[l].fu_type));
                check_value({tag, " dest"}, dest, 32'(retire[l].dest_reg_idx));
                if (is_alu_br && dest != 32'd0) begin
                    check_value({tag, " result"}, vec_mem[w+4], retire[l].result);
                end
                if (fu == rv_pkg::fu_br) begin // target only means something for br
                    check_value({tag, " target"}, vec_mem[w+5], retire[l].target);
                end
            end
        end
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        idle_bundle();
        $readmemh("tb/rv_core_vectors.hex", vec_mem);
        vec_count = 0;
        while (vec_count < max_lines && vec_mem[vec_count*line_words] !== 32'hffff_ffff) begin
            vec_count++;
        end
        if (vec_count == 0 || vec_count == max_lines) begin
            $display("vector file missing, empty or without its end marker");
            $display("*** FAILED ***");
            $fatal(1, "no vectors");
        end

        repeat (5) @(posedge clock);
        @(negedge clock);
        // pipeline must be empty coming out of reset
        check_value("reset halted", 32'd0, 32'(halted));
        for (int l = 0; l < N; l++) begin
            check_value($sformatf("reset lane %0d valid", l), 32'd0, 32'(retire[l].valid));
            check_value($sformatf("reset lane %0d write enable", l), 32'd0,
                        32'(dut_i.wb_ports[l].en));
        end
        reset = 1'b0;

        for (int i = 0; i < vec_count + 2; i++) begin
            if (i >= 2) begin
                check_bundle(i - 2);   // two cycles behind the drive
            end
            if (i < vec_count) begin
                drive_bundle(i);
            end else begin
                idle_bundle();
            end
            @(negedge clock);
            check_value("assertion failures", 32'd0,
                        32'(dut_i.stage_wb_i.sva_i.fail_count));
        end

        $display("*** PASSED ***");
        $finish;
    end

    // watchdog, scaled by the number of bundles
    initial begin
        #1;
        #((vec_count + 20) * 40);
        $display("watchdog timeout, the run did not reach its end in time");
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    end

endmodule
